/* fetch_issue_top.f */
+incdir+include
rtl/fetch_issue_pkg.sv
rtl/instr_decoder.sv
rtl/pc_control.sv
rtl/operand_resolve.sv
rtl/issue_stage.sv
rtl/fetch_issue_top.sv
dv/fetch_issue_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_issue_tb \
  -f fetch_issue_top.f -Mdir obj_dir -o fetch_issue_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/fetch_issue_sim > sim.log 2>&1 ; cat sim.log

grep -qx "test passed" sim.log && echo "simulation ok" \
  || { echo "simulation reported a failure"; exit 1; }

/* include/fetch_issue_ref.svh */
`ifndef FETCH_ISSUE_REF_SVH
`define FETCH_ISSUE_REF_SVH

// expects fetch_issue_pkg imported and NUM_CDB declared in the including scope

function automatic decoded_t ref_decode(input logic [31:0] instr);
  decoded_t d;
  logic [2:0] f3;
  alu_op_e alu_tab [8] = '{ALU_ADD, ALU_SLL, ALU_LT, ALU_LTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
  alu_op_e br_tab [8] = '{ALU_EQ, ALU_NE, ALU_NOP, ALU_NOP, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
  f3 = instr[14:12];
  d = '0;
  d.cls = CLS_ILLEGAL;
  d.rs1 = instr[19:15];
  d.rs2 = instr[24:20];
  d.lsb_len = (f3[1:0] == 2'b10) ? 2'b11 : f3[1:0];
  d.load_signed = !f3[2];
  case (instr[6:0])
    7'h37: d.cls = CLS_LUI;
    7'h17: d.cls = CLS_AUIPC;
    7'h6f: d.cls = CLS_JAL;
    7'h63: d.cls = (f3[2:1] == 2'b01) ? CLS_ILLEGAL : CLS_BRANCH;
    7'h03: d.cls = (f3 == 3'd3 || f3 >= 3'd6) ? CLS_ILLEGAL : CLS_LOAD;
    7'h23: d.cls = (f3 >= 3'd3) ? CLS_ILLEGAL : CLS_STORE;
    7'h13: d.cls = CLS_OP_IMM;
    7'h33: d.cls = CLS_OP;
    default: d.cls = CLS_ILLEGAL;
  endcase
  case (d.cls)
    CLS_LUI, CLS_AUIPC: d.imm = {instr[31:12], 12'h000};
    CLS_JAL: d.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    CLS_BRANCH: d.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    CLS_STORE: d.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    default: d.imm = {{20{instr[31]}}, instr[31:20]};
  endcase
  d.use_rs1 = d.cls inside {CLS_BRANCH, CLS_LOAD, CLS_STORE, CLS_OP_IMM, CLS_OP};
  d.use_rs2 = d.cls inside {CLS_BRANCH, CLS_STORE, CLS_OP};
  if (d.cls == CLS_BRANCH) d.alu_op = br_tab[f3];
  if (d.cls inside {CLS_OP_IMM, CLS_OP}) d.alu_op = alu_tab[f3];
  if (d.cls inside {CLS_OP_IMM, CLS_OP} && f3 == 3'd5 && instr[30]) d.alu_op = ALU_SRA;
  if (d.cls == CLS_OP && f3 == 3'd0 && instr[30]) d.alu_op = ALU_SUB;
  if (d.cls inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_LOAD, CLS_OP_IMM, CLS_OP}) d.rd = instr[11:7];
  return d;
endfunction

function automatic logic [31:0] ref_next_pc(input logic [31:0] pc, input decoded_t d,
                                            input logic predict_jump);
  if (d.cls == CLS_ILLEGAL) return pc;
  if (d.cls == CLS_JAL || (d.cls == CLS_BRANCH && predict_jump)) return pc + d.imm;
  return pc + 32'd4;
endfunction

// lw is the predictor index width of the DUT
function automatic logic [31:0] ref_rob_branch_value(input logic [31:0] pc, input decoded_t d,
                                                     input logic predict_jump, input int lw);
  logic [31:0] alt;
  logic [31:0] idx;
  alt = predict_jump ? pc + 32'd4 : pc + d.imm;
  idx = (pc >> 2) & ((32'd1 << lw) - 32'd1);
  return (idx << (32 - lw)) | (alt & ((32'd1 << (32 - lw)) - 32'd4)) | {30'd0, predict_jump, 1'b0};
endfunction

function automatic operand_t ref_resolve(input logic [4:0] reg_id, input rf_read_t rf,
                                         input rob_read_t rob, input logic last_strobe,
                                         input logic [ROB_WIDTH-1:0] last_tag,
                                         input rob_issue_t last_rob, input cdb_t cdb [NUM_CDB]);
  operand_t o;
  int i;
  o = '{value: '0, tag: rf.tag, valid: 1'b0};
  if (reg_id == 5'd0) o.valid = 1'b1;
  else if (rf.valid) o = '{value: rf.value, tag: rf.tag, valid: 1'b1};
  else if (rob.ready) o = '{value: rob.value, tag: rf.tag, valid: 1'b1};
  else if (last_strobe && last_rob.value_ready && last_tag == rf.tag)
    o = '{value: last_rob.value, tag: rf.tag, valid: 1'b1};
  else
    for (i = 0; i < NUM_CDB && !o.valid; i++)
      if (cdb[i].valid && cdb[i].tag == rf.tag) o = '{value: cdb[i].value, tag: rf.tag, valid: 1'b1};
  return o;
endfunction

`endif

/* dv/fetch_issue_tb.sv */
`timescale 1ns/10ps

module fetch_issue_tb import fetch_issue_pkg::*; ();

  localparam int LOCAL_WIDTH     = 6;
  localparam int NUM_CDB         = 3;
  localparam int CLK_PERIOD      = 100;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 60;  // longest test runs about 45 cycles

  localparam logic [31:0] ADD_X7 = 32'h0062_83b3;  // add x7, x5, x6
  localparam logic [31:0] LUI_X5 = 32'habcd_e2b7;  // lui x5, 0xabcde

  `include "fetch_issue_ref.svh"

  logic                   clk_in = 1'b0;
  logic                   rst_in;
  logic                   fetch_req;
  logic [XLEN-1:0]        fetch_addr;
  logic                   fetch_done;
  logic [XLEN-1:0]        fetch_instr;
  logic                   rs_full;
  logic                   rob_full;
  logic                   lsb_full;
  logic [REG_ID_W-1:0]    rf_id_rs1;
  logic [REG_ID_W-1:0]    rf_id_rs2;
  logic [REG_ID_W-1:0]    rf_id_rd;
  logic [ROB_WIDTH-1:0]   rf_tag_rd;
  rf_read_t               rf_rs1;
  rf_read_t               rf_rs2;
  logic [ROB_WIDTH-1:0]   rob_index;
  rob_read_t              rob_rs1;
  rob_read_t              rob_rs2;
  cdb_t                   cdb [NUM_CDB];
  logic [LOCAL_WIDTH-1:0] predict_addr;
  logic                   predict_jump;
  logic                   rs_issue_strobe;
  rs_issue_t              rs_issue;
  logic                   rob_issue_strobe;
  rob_issue_t             rob_issue;
  logic                   lsb_issue_strobe;
  lsb_issue_t             lsb_issue;
  logic                   clear_signal;
  logic [XLEN-1:0]        correct_pc;

  // expected state, advanced at each rising edge
  logic            chk_en = 1'b0;
  logic [XLEN-1:0] m_pc;
  logic            m_rs_stb;
  logic            m_rob_stb;
  logic            m_lsb_stb;
  rs_issue_t       m_rs;
  rob_issue_t      m_rob;
  lsb_issue_t      m_lsb;

  int n_checks = 0;
  int n_errors = 0;
  int n_tests  = 0;
  int chk_mark = 0;
  int err_mark = 0;

  fetch_issue_top #(.LOCAL_WIDTH(LOCAL_WIDTH), .NUM_CDB(NUM_CDB)) dut_i (.*);

  always #(CLK_PERIOD / 2) clk_in = ~clk_in;

  task automatic compare_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // expected ROB record for an instruction fetched at pc
  function automatic rob_issue_t expected_rob(input decoded_t d, input logic [XLEN-1:0] pc,
                                              input logic pj);
    rob_issue_t r;
    r.kind = (d.cls == CLS_BRANCH) ? ROB_BRANCH : (d.cls == CLS_STORE) ? ROB_STORE : ROB_REG;
    r.value_ready = d.cls inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_STORE};
    r.rd = d.rd;
    case (d.cls)
      CLS_LUI:    r.value = d.imm;
      CLS_AUIPC:  r.value = pc + d.imm;
      CLS_JAL:    r.value = pc + 32'd4;  // link address
      CLS_BRANCH: r.value = ref_rob_branch_value(pc, d, pj, LOCAL_WIDTH);
      default:    r.value = '0;
    endcase
    return r;
  endfunction

  function automatic rf_read_t rand_rf();
    return '{value: $urandom, tag: ROB_WIDTH'($urandom), valid: 1'b1};
  endfunction

  function automatic rf_read_t pending_rf(input logic [ROB_WIDTH-1:0] t);
    return '{value: $urandom, tag: t, valid: 1'b0};
  endfunction

  function automatic logic [ROB_WIDTH-1:0] rand_idx();
    return ROB_WIDTH'($urandom);
  endfunction

  task automatic init_inputs();
    fetch_done = 1'b0;
    fetch_instr = '0;  // opcode 0 decodes as illegal
    rs_full = 1'b0;
    rob_full = 1'b0;
    lsb_full = 1'b0;
    rf_rs1 = '0;
    rf_rs2 = '0;
    rob_index = '0;
    rob_rs1 = '0;
    rob_rs2 = '0;
    for (int i = 0; i < NUM_CDB; i++) begin
      cdb[i] = '0;
    end
    predict_jump = 1'b0;
    clear_signal = 1'b0;
    correct_pc = '0;
  endtask

  // extra inputs set right after this returns apply to the same cycle
  task automatic drive_instr(input logic [XLEN-1:0] instr, input logic pj,
                             input rf_read_t r1, input rf_read_t r2,
                             input logic [ROB_WIDTH-1:0] idx);
    @(negedge clk_in);
    init_inputs();
    fetch_done = 1'b1;
    fetch_instr = instr;
    predict_jump = pj;
    rf_rs1 = r1;
    rf_rs2 = r2;
    rob_index = idx;
  endtask

  task automatic idle_cycle();
    @(negedge clk_in);
    init_inputs();
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    $display("[%0d] %s: %0d checks, %0d errors", n_tests, name,
             n_checks - chk_mark, n_errors - err_mark);
    chk_mark = n_checks;
    err_mark = n_errors;
  endtask

  // samples the inputs at the edge and works out what the DUT must show next
  always @(posedge clk_in) begin : model_step
    decoded_t             d;
    logic                 go;
    logic                 full;
    logic [ROB_WIDTH-1:0] tag;
    logic [REG_ID_W-1:0]  id1;
    logic [REG_ID_W-1:0]  id2;
    operand_t             o1;
    operand_t             o2;
    if (rst_in) begin
      m_pc = '0;
      m_rs_stb = 1'b0;
      m_rob_stb = 1'b0;
      m_lsb_stb = 1'b0;
      m_rob = '0;
      chk_en = 1'b1;
    end else begin
      full = rs_full || rob_full || lsb_full;
      compare_value("fetch_req", 128'(fetch_req), 128'(!full));
      go = fetch_done && !full && !clear_signal;  // clear wins
      d = ref_decode(fetch_instr);
      tag = rob_index + ROB_WIDTH'(m_rob_stb);
      id1 = d.use_rs1 ? d.rs1 : 5'd0;
      id2 = d.use_rs2 ? d.rs2 : 5'd0;
      compare_value("rf_tag_rd", 128'(rf_tag_rd), 128'(tag));
      compare_value("predict_addr", 128'(predict_addr),
                    128'((m_pc >> 2) & ((32'd1 << LOCAL_WIDTH) - 32'd1)));
      if (d.cls != CLS_ILLEGAL) begin
        compare_value("rf_id_rs1", 128'(rf_id_rs1), 128'(id1));
        compare_value("rf_id_rs2", 128'(rf_id_rs2), 128'(id2));
        compare_value("rf_id_rd", 128'(rf_id_rd), 128'(d.rd));
      end
      o1 = ref_resolve(id1, rf_rs1, rob_rs1, m_rob_stb, rob_index, m_rob, cdb);
      o2 = ref_resolve(id2, rf_rs2, rob_rs2, m_rob_stb, rob_index, m_rob, cdb);
      m_rs_stb = go && (d.cls inside {CLS_BRANCH, CLS_OP_IMM, CLS_OP});
      m_lsb_stb = go && (d.cls inside {CLS_LOAD, CLS_STORE});
      if (m_rs_stb) begin
        m_rs.alu_op = d.alu_op;
        m_rs.opnd1 = o1;
        if (d.use_rs2) begin
          m_rs.opnd2 = o2;
        end else begin
          m_rs.opnd2 = '{value: d.imm, tag: '0, valid: 1'b1};
        end
        m_rs.dest_tag = tag;
      end
      if (m_lsb_stb) begin
        m_lsb = '{wr: d.cls == CLS_STORE, is_signed: d.load_signed, len: d.lsb_len,
                  addr: o1, value: o2, offset: d.imm[11:0], dest_tag: tag};
      end
      if (go && d.cls != CLS_ILLEGAL) begin
        m_rob = expected_rob(d, m_pc, predict_jump);
      end
      m_rob_stb = go && d.cls != CLS_ILLEGAL;
      if (clear_signal) begin
        m_pc = correct_pc;
      end else if (go) begin
        m_pc = ref_next_pc(m_pc, d, predict_jump);
      end
    end
  end

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk_in) begin
    if (chk_en) begin
      compare_value("fetch_addr", 128'(fetch_addr), 128'(m_pc));
      compare_value("rs strobe", 128'(rs_issue_strobe), 128'(m_rs_stb));
      compare_value("rob strobe", 128'(rob_issue_strobe), 128'(m_rob_stb));
      compare_value("lsb strobe", 128'(lsb_issue_strobe), 128'(m_lsb_stb));
      if (m_rs_stb) compare_value("rs_issue", 128'(rs_issue), 128'(m_rs));
      if (m_rob_stb) compare_value("rob_issue", 128'(rob_issue), 128'(m_rob));
      if (m_lsb_stb) compare_value("lsb_issue", 128'(lsb_issue), 128'(m_lsb));
    end
  end

  initial begin
    #(CLK_PERIOD * (NUM_TESTS * CYCLES_PER_TEST + 10));
    $display("watchdog expired after %0d cycles, the tests never reached the end",
             NUM_TESTS * CYCLES_PER_TEST + 10);
    $display("test failed");
    $finish;
  end

  initial begin
    logic [31:0] instr;
    logic [2:0]  f3;
    void'($urandom(32'h08d65714));
    rst_in = 1'b1;
    init_inputs();
    repeat (4) @(negedge clk_in);
    rst_in = 1'b0;

    idle_cycle();
    drive_instr(32'h0020_8193, 1'b0, rand_rf(), rand_rf(), 4'd2);  // addi x3, x1, 2
    clear_signal = 1'b1;
    correct_pc = 32'h0000_1240;
    drive_instr(32'hffff_ffff, 1'b0, rand_rf(), rand_rf(), 4'd3);  // unknown opcode
    idle_cycle();
    idle_cycle();
    finish_test("reset and redirect");

    for (int i = 0; i < 40; i++) begin
      instr = $urandom;
      instr[6:0] = ($urandom % 2 == 0) ? 7'h33 : 7'h13;
      drive_instr(instr, 1'b0, rand_rf(), rand_rf(), rand_idx());
    end
    idle_cycle();
    finish_test("op and op-imm");

    for (int i = 0; i < 18; i++) begin
      instr = $urandom;
      case (i % 3)
        0: instr[6:0] = 7'h37;
        1: instr[6:0] = 7'h17;
        default: begin
          instr[6:0] = 7'h6f;
          instr[21] = 1'b0;  // keeps the jump target word aligned
        end
      endcase
      drive_instr(instr, 1'($urandom), rand_rf(), rand_rf(), rand_idx());
    end
    idle_cycle();
    finish_test("lui auipc jal");

    for (int i = 0; i < 24; i++) begin
      instr = $urandom;
      f3 = 3'($urandom);
      if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // skip the two unused compares
      instr[6:0] = 7'h63;
      instr[14:12] = f3;
      instr[8] = 1'b0;
      drive_instr(instr, i[0], rand_rf(), rand_rf(), rand_idx());
    end
    idle_cycle();
    finish_test("branches");

    for (int i = 0; i < 20; i++) begin
      instr = $urandom;
      if (i[0]) begin
        instr[6:0] = 7'h23;
        instr[14:12] = 3'($urandom % 3);
      end else begin
        f3 = 3'($urandom % 5);
        if (f3 == 3'd3) f3 = 3'd5;  // lhu
        instr[6:0] = 7'h03;
        instr[14:12] = f3;
      end
      drive_instr(instr, 1'b0, rand_rf(), rand_rf(), rand_idx());
    end
    idle_cycle();
    finish_test("loads and stores");

    // rob answer ahead of a result bus carrying the same tag
    drive_instr(ADD_X7, 1'b0, pending_rf(4'h3), pending_rf(4'h9), 4'h6);
    rob_rs1 = '{value: $urandom, ready: 1'b1};
    cdb[0] = '{valid: 1'b1, tag: 4'h3, value: $urandom};
    cdb[1] = '{valid: 1'b1, tag: 4'h9, value: $urandom};
    idle_cycle();
    drive_instr(ADD_X7, 1'b0, pending_rf(4'h3), pending_rf(4'h9), 4'h7);
    cdb[0] = '{valid: 1'b1, tag: 4'h5, value: $urandom};
    cdb[1] = '{valid: 1'b1, tag: 4'h3, value: $urandom};
    cdb[2] = '{valid: 1'b1, tag: 4'h9, value: $urandom};
    idle_cycle();
    drive_instr(ADD_X7, 1'b0, pending_rf(4'h3), pending_rf(4'h9), 4'h8);
    cdb[0] = '{valid: 1'b1, tag: 4'h1, value: $urandom};  // no match, both stay pending
    idle_cycle();
    drive_instr(LUI_X5, 1'b0, rand_rf(), rand_rf(), 4'hb);
    drive_instr(ADD_X7, 1'b0, pending_rf(4'hb), rand_rf(), 4'hb);  // x5 from the lui
    idle_cycle();
    drive_instr(ADD_X7, 1'b0, rand_rf(), rand_rf(), 4'h2);
    rob_full = 1'b1;
    drive_instr(ADD_X7, 1'b0, rand_rf(), rand_rf(), 4'h2);
    rs_full = 1'b1;
    drive_instr(ADD_X7, 1'b0, rand_rf(), rand_rf(), 4'h2);
    lsb_full = 1'b1;
    idle_cycle();
    idle_cycle();
    finish_test("operand priority and back-pressure");

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* rtl/fetch_issue_top.sv */
`timescale 1ns/10ps

module fetch_issue_top import fetch_issue_pkg::*; #(
  parameter int LOCAL_WIDTH = 6,
  parameter int NUM_CDB     = 3
) (
  input  logic                   clk_in,
  input  logic                   rst_in,
  // instruction memory
  output logic                   fetch_req,
  output logic [XLEN-1:0]        fetch_addr,
  input  logic                   fetch_done,
  input  logic [XLEN-1:0]        fetch_instr,
  input  logic                   rs_full,
  input  logic                   rob_full,
  input  logic                   lsb_full,
  // register file
  output logic [REG_ID_W-1:0]    rf_id_rs1,
  output logic [REG_ID_W-1:0]    rf_id_rs2,
  output logic [REG_ID_W-1:0]    rf_id_rd,
  output logic [ROB_WIDTH-1:0]   rf_tag_rd,
  input  rf_read_t               rf_rs1,
  input  rf_read_t               rf_rs2,
  // reorder buffer, looked up with the RF tags
  input  logic [ROB_WIDTH-1:0]   rob_index,
  input  rob_read_t              rob_rs1,
  input  rob_read_t              rob_rs2,
  input  cdb_t                   cdb [NUM_CDB],
  output logic [LOCAL_WIDTH-1:0] predict_addr,
  input  logic                   predict_jump,
  output logic                   rs_issue_strobe,
  output rs_issue_t              rs_issue,
  output logic                   rob_issue_strobe,
  output rob_issue_t             rob_issue,
  output logic                   lsb_issue_strobe,
  output lsb_issue_t             lsb_issue,
  input  logic                   clear_signal,
  input  logic [XLEN-1:0]        correct_pc
);

  logic                 issue_go;
  decoded_t             dec;
  logic [XLEN-1:0]      pc;
  logic [XLEN-1:0]      branch_target;
  operand_t             opnd1;
  operand_t             opnd2;
  logic [ROB_WIDTH-1:0] rob_tag;

  assign fetch_req = !(rob_full || rs_full || lsb_full);
  assign issue_go = fetch_done && fetch_req;
  assign fetch_addr = pc;

  assign rf_id_rs1 = dec.use_rs1 ? dec.rs1 : '0;  // unread fields look up x0
  assign rf_id_rs2 = dec.use_rs2 ? dec.rs2 : '0;
  assign rf_id_rd = dec.rd;
  assign rf_tag_rd = rob_tag;

  instr_decoder u_decoder (
    .instr (fetch_instr),
    .dec   (dec)
  );

  pc_control #(.LOCAL_WIDTH(LOCAL_WIDTH)) u_pc (
    .clk_in, .rst_in, .issue_go, .dec, .predict_jump, .clear_signal, .correct_pc,
    .pc, .branch_target, .predict_addr
  );

  operand_resolve #(.NUM_CDB(NUM_CDB)) u_resolve_rs1 (
    .reg_id (rf_id_rs1), .rf (rf_rs1), .rob (rob_rs1),
    .last_rob_strobe (rob_issue_strobe), .last_rob_tag (rob_index), .last_rob (rob_issue),
    .cdb, .opnd (opnd1)
  );

  operand_resolve #(.NUM_CDB(NUM_CDB)) u_resolve_rs2 (
    .reg_id (rf_id_rs2), .rf (rf_rs2), .rob (rob_rs2),
    .last_rob_strobe (rob_issue_strobe), .last_rob_tag (rob_index), .last_rob (rob_issue),
    .cdb, .opnd (opnd2)
  );

  issue_stage #(.LOCAL_WIDTH(LOCAL_WIDTH)) u_issue (
    .clk_in, .rst_in, .issue_go, .clear_signal, .dec, .pc, .branch_target,
    .predict_jump, .predict_addr, .rob_index, .opnd1, .opnd2,
    .rs_issue_strobe, .rs_issue, .rob_issue_strobe, .rob_issue,
    .lsb_issue_strobe, .lsb_issue, .rob_tag
  );

endmodule

/* rtl/issue_stage.sv */
`timescale 1ns/10ps

module issue_stage import fetch_issue_pkg::*; #(
  parameter int LOCAL_WIDTH = 6
) (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   issue_go,
  input  logic                   clear_signal,
  input  decoded_t               dec,
  input  logic [XLEN-1:0]        pc,
  input  logic [XLEN-1:0]        branch_target,
  input  logic                   predict_jump,
  input  logic [LOCAL_WIDTH-1:0] predict_addr,
  input  logic [ROB_WIDTH-1:0]   rob_index,
  input  operand_t               opnd1,
  input  operand_t               opnd2,
  output logic                   rs_issue_strobe,
  output rs_issue_t              rs_issue,
  output logic                   rob_issue_strobe,
  output rob_issue_t             rob_issue,
  output logic                   lsb_issue_strobe,
  output lsb_issue_t             lsb_issue,
  output logic [ROB_WIDTH-1:0]   rob_tag
);

  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] alt_pc;
  logic            rs_go;
  logic            rob_go;
  logic            lsb_go;
  rs_issue_t       rs_next;
  rob_issue_t      rob_next;
  lsb_issue_t      lsb_next;

  assign pc_plus4 = pc + 32'd4;
  assign alt_pc = predict_jump ? pc_plus4 : branch_target;  // path the prediction skips

  // ROB slot for the instruction issuing now; rob_index still points
  // at the entry written from last cycle's strobe
  assign rob_tag = rob_issue_strobe ? rob_index + 1'b1 : rob_index;

  assign rob_go = issue_go && (dec.cls != CLS_ILLEGAL);
  assign rs_go  = issue_go && (dec.cls inside {CLS_BRANCH, CLS_OP_IMM, CLS_OP});
  assign lsb_go = issue_go && (dec.cls inside {CLS_LOAD, CLS_STORE});

  always_comb begin
    rs_next.alu_op = dec.alu_op;
    rs_next.opnd1 = opnd1;
    rs_next.opnd2 = opnd2;
    if (!dec.use_rs2) begin
      rs_next.opnd2 = '{value: dec.imm, tag: '0, valid: 1'b1};  // OP-IMM immediate
    end
    rs_next.dest_tag = rob_tag;
  end

  always_comb begin
    rob_next.kind = ROB_REG;
    rob_next.value_ready = 1'b0;
    rob_next.value = '0;
    rob_next.rd = dec.rd;
    case (dec.cls)
      CLS_LUI: begin
        rob_next.value_ready = 1'b1;
        rob_next.value = dec.imm;
      end
      CLS_AUIPC: begin
        rob_next.value_ready = 1'b1;
        rob_next.value = branch_target;  // pc + upper imm
      end
      CLS_JAL: begin
        rob_next.value_ready = 1'b1;
        rob_next.value = pc_plus4;  // link address
      end
      CLS_BRANCH: begin
        rob_next.kind = ROB_BRANCH;
        // predictor index | alternative pc | predicted direction | 0
        rob_next.value = {predict_addr, alt_pc[XLEN-1-LOCAL_WIDTH:2], predict_jump, 1'b0};
      end
      CLS_STORE: begin
        rob_next.kind = ROB_STORE;
        rob_next.value_ready = 1'b1;
      end
      default: rob_next.value = '0;
    endcase
  end

  always_comb begin
    lsb_next.wr = (dec.cls == CLS_STORE);
    lsb_next.is_signed = dec.load_signed;
    lsb_next.len = dec.lsb_len;
    lsb_next.addr = opnd1;  // base register
    lsb_next.value = opnd2;  // store data, x0 for loads
    lsb_next.offset = dec.imm[11:0];
    lsb_next.dest_tag = rob_tag;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in || clear_signal) begin
      rs_issue_strobe <= 1'b0;
      rob_issue_strobe <= 1'b0;
      lsb_issue_strobe <= 1'b0;
    end else begin
      rs_issue_strobe <= rs_go;  // one-cycle strobes
      rob_issue_strobe <= rob_go;
      lsb_issue_strobe <= lsb_go;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rs_go) rs_issue <= rs_next;
    if (rob_go) rob_issue <= rob_next;
    if (lsb_go) lsb_issue <= lsb_next;
  end

  a_rs_lsb_exclusive: assert property (@(posedge clk_in) disable iff (rst_in)
    !(rs_issue_strobe && lsb_issue_strobe))
    else $error("RS and LSB issued in the same cycle");

endmodule

/* rtl/operand_resolve.sv */
`timescale 1ns/10ps

module operand_resolve import fetch_issue_pkg::*; #(
  parameter int NUM_CDB = 3
) (
  input  logic [REG_ID_W-1:0]  reg_id,
  input  rf_read_t             rf,
  input  rob_read_t            rob,
  input  logic                 last_rob_strobe,
  input  logic [ROB_WIDTH-1:0] last_rob_tag,
  input  rob_issue_t           last_rob,
  input  cdb_t                 cdb [NUM_CDB],
  output operand_t             opnd
);

  logic dup_tag;

  always_comb begin
    opnd = '{value: '0, tag: rf.tag, valid: 1'b0};
    if (reg_id == '0) begin
      opnd.valid = 1'b1;  // x0 reads as zero
    end else if (rf.valid) begin
      opnd.value = rf.value;
      opnd.valid = 1'b1;
    end else if (rob.ready) begin
      opnd.value = rob.value;
      opnd.valid = 1'b1;
    end else if (last_rob_strobe && last_rob.value_ready && last_rob_tag == rf.tag) begin
      // entry goes into the ROB this cycle, not visible there yet
      opnd.value = last_rob.value;
      opnd.valid = 1'b1;
    end else begin
      for (int i = NUM_CDB - 1; i >= 0; i--) begin  // descending so the lowest hit stays
        if (cdb[i].valid && cdb[i].tag == rf.tag) begin
          opnd.value = cdb[i].value;
          opnd.valid = 1'b1;
        end
      end
    end
  end

  always_comb begin
    dup_tag = 1'b0;
    for (int i = 0; i < NUM_CDB; i++) begin
      for (int j = i + 1; j < NUM_CDB; j++) begin
        if (cdb[i].valid && cdb[j].valid && cdb[i].tag == cdb[j].tag) begin
          dup_tag = 1'b1;
        end
      end
    end
  end

  // each ROB tag has exactly one producer on the result buses
  always_comb begin
    assert final (!dup_tag) else $error("two result buses carry the same tag");
  end

endmodule

/* rtl/pc_control.sv */
`timescale 1ns/10ps

module pc_control import fetch_issue_pkg::*; #(
  parameter int LOCAL_WIDTH = 6
) (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   issue_go,
  input  decoded_t               dec,
  input  logic                   predict_jump,
  input  logic                   clear_signal,
  input  logic [XLEN-1:0]        correct_pc,
  output logic [XLEN-1:0]        pc,
  output logic [XLEN-1:0]        branch_target,
  output logic [LOCAL_WIDTH-1:0] predict_addr
);

  logic [XLEN-1:0] pc_plus4;

  assign pc_plus4 = pc + 32'd4;
  assign branch_target = pc + dec.imm;  // also pc + upper imm for AUIPC
  assign predict_addr = pc[LOCAL_WIDTH+1:2];  // counter group select

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc <= '0;
    end else if (clear_signal) begin
      pc <= correct_pc;  // mispredict redirect wins over issue
    end else if (issue_go) begin
      case (dec.cls)
        CLS_JAL:     pc <= branch_target;
        CLS_BRANCH:  pc <= predict_jump ? branch_target : pc_plus4;
        CLS_ILLEGAL: pc <= pc;  // unknown encoding, hold
        default:     pc <= pc_plus4;
      endcase
    end
  end

  // targets and redirects all come from outside sources
  a_pc_aligned: assert property (@(posedge clk_in) disable iff (rst_in) pc[1:0] == 2'b00)
    else $error("PC %h not word aligned", pc);

endmodule

/* rtl/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder import fetch_issue_pkg::*; (
  input  logic [XLEN-1:0] instr,
  output decoded_t        dec
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec = '0;
    dec.cls = CLS_ILLEGAL;
    dec.alu_op = ALU_NOP;
    dec.rs1 = instr[19:15];
    dec.rs2 = instr[24:20];
    dec.lsb_len = {funct3[1], funct3[1] | funct3[0]};  // 00/01/10 -> byte/half/word
    dec.load_signed = ~funct3[2];  // LBU and LHU have funct3[2] set
    case (opcode)
      7'b0110111: begin
        dec.cls = CLS_LUI;
        dec.imm = imm_u;
      end
      7'b0010111: begin
        dec.cls = CLS_AUIPC;
        dec.imm = imm_u;
      end
      7'b1101111: begin
        dec.cls = CLS_JAL;
        dec.imm = imm_j;
      end
      7'b1100011: begin
        dec.cls = CLS_BRANCH;
        dec.imm = imm_b;
        dec.use_rs1 = 1'b1;
        dec.use_rs2 = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = ALU_EQ;
          3'b001:  dec.alu_op = ALU_NE;
          3'b100:  dec.alu_op = ALU_LT;
          3'b101:  dec.alu_op = ALU_GE;
          3'b110:  dec.alu_op = ALU_LTU;
          3'b111:  dec.alu_op = ALU_GEU;
          default: dec.cls = CLS_ILLEGAL;  // 010 and 011 are unused
        endcase
      end
      7'b0000011: begin
        dec.cls = (funct3 inside {3'b011, 3'b110, 3'b111}) ? CLS_ILLEGAL : CLS_LOAD;
        dec.imm = imm_i;
        dec.use_rs1 = 1'b1;
      end
      7'b0100011: begin
        dec.cls = (funct3[2] || funct3[1:0] == 2'b11) ? CLS_ILLEGAL : CLS_STORE;
        dec.imm = imm_s;
        dec.use_rs1 = 1'b1;
        dec.use_rs2 = 1'b1;
      end
      7'b0010011, 7'b0110011: begin
        // opcode bit 5 tells OP from OP-IMM
        dec.cls = opcode[5] ? CLS_OP : CLS_OP_IMM;
        dec.imm = imm_i;
        dec.use_rs1 = 1'b1;
        dec.use_rs2 = opcode[5];
        case (funct3)
          3'b000: dec.alu_op = (opcode[5] && instr[30]) ? ALU_SUB : ALU_ADD;
          3'b001: dec.alu_op = ALU_SLL;
          3'b010: dec.alu_op = ALU_LT;
          3'b011: dec.alu_op = ALU_LTU;
          3'b100: dec.alu_op = ALU_XOR;
          3'b101: dec.alu_op = instr[30] ? ALU_SRA : ALU_SRL;
          3'b110: dec.alu_op = ALU_OR;
          3'b111: dec.alu_op = ALU_AND;
        endcase
      end
      default: dec.cls = CLS_ILLEGAL;
    endcase
    // only register writers rename rd, x0 otherwise
    if (dec.cls inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_LOAD, CLS_OP_IMM, CLS_OP}) begin
      dec.rd = instr[11:7];
    end
  end

  always_comb begin
    if (dec.cls == CLS_OP || dec.cls == CLS_OP_IMM) begin
      assert final (dec.alu_op != ALU_NOP)
        else $error("ALU class decoded to NOP, instr %h", instr);
    end
  end

endmodule

/* rtl/fetch_issue_pkg.sv */
package fetch_issue_pkg;

  localparam int ROB_WIDTH = 4;  // ROB tag width
  localparam int XLEN      = 32;
  localparam int REG_ID_W  = 5;

  // ALU operation handed to the reservation stations
  typedef enum logic [3:0] {
    ALU_NOP,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_ADD,
    ALU_SUB,
    ALU_SRL,
    ALU_SRA,
    ALU_SLL,
    ALU_LT,
    ALU_LTU,
    ALU_EQ,
    ALU_NE,
    ALU_GE,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    ROB_REG    = 2'b00,
    ROB_STORE  = 2'b01,
    ROB_BRANCH = 2'b10
  } rob_kind_e;

  typedef enum logic [3:0] {
    CLS_LUI,
    CLS_AUIPC,
    CLS_JAL,
    CLS_BRANCH,
    CLS_LOAD,
    CLS_STORE,
    CLS_OP_IMM,
    CLS_OP,
    CLS_ILLEGAL
  } instr_class_e;

  typedef struct packed {
    instr_class_e        cls;
    alu_op_e             alu_op;
    logic [REG_ID_W-1:0] rs1;
    logic [REG_ID_W-1:0] rs2;
    logic [REG_ID_W-1:0] rd;           // zero when the class writes no register
    logic [XLEN-1:0]     imm;          // sign-extended, already picked for the class
    logic                use_rs1;
    logic                use_rs2;
    logic [1:0]          lsb_len;      // byte 00, half 01, word 11
    logic                load_signed;
  } decoded_t;

  typedef struct packed {
    logic                 valid;
    logic [ROB_WIDTH-1:0] tag;
    logic [XLEN-1:0]      value;
  } cdb_t;

  typedef struct packed {
    logic [XLEN-1:0]      value;
    logic [ROB_WIDTH-1:0] tag;
    logic                 valid;
  } rf_read_t;

  typedef struct packed {
    logic [XLEN-1:0] value;
    logic            ready;
  } rob_read_t;

  typedef struct packed {
    logic [XLEN-1:0]      value;
    logic [ROB_WIDTH-1:0] tag;    // producer tag while not valid
    logic                 valid;
  } operand_t;

  typedef struct packed {
    alu_op_e              alu_op;
    operand_t             opnd1;
    operand_t             opnd2;
    logic [ROB_WIDTH-1:0] dest_tag;
  } rs_issue_t;

  typedef struct packed {
    rob_kind_e           kind;
    logic                value_ready;
    logic [XLEN-1:0]     value;
    logic [REG_ID_W-1:0] rd;
  } rob_issue_t;

  typedef struct packed {
    logic                 wr;         // 1 for store
    logic                 is_signed;
    logic [1:0]           len;
    operand_t             addr;
    operand_t             value;
    logic [11:0]          offset;
    logic [ROB_WIDTH-1:0] dest_tag;
  } lsb_issue_t;

endpackage
